/* Bender.yml */
package:
  name: axil_mem

sources:
  - verilog/axil_bridge_pkg.sv
  - verilog/resp_delay_timer.sv
  - verilog/host_mem.sv
  - verilog/axil_client_adaptor.sv
  - verilog/axil_mem_top.sv
  - target: test
    files:
      - tests/axil_mem_checker.sv
      - tests/axil_mem_tb.sv

/* project.f */
verilog/axil_bridge_pkg.sv
verilog/resp_delay_timer.sv
verilog/host_mem.sv
verilog/axil_client_adaptor.sv
verilog/axil_mem_top.sv
tests/axil_mem_checker.sv
tests/axil_mem_tb.sv

/* tests/axil_mem_checker.sv */
`default_nettype none

module axil_mem_checker
(
  input wire logic                            clk_i,
  input wire logic                            reset_i,
  input wire logic [2:0]                      awprot_i,
  input wire logic                            cmd_v_i,
  input wire logic                            cmd_ready_i,
  input wire logic                            rvalid_i,
  input wire logic                            rready_i,
  input wire logic                            bvalid_i,
  input wire axil_bridge_pkg::adaptor_state_e state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  awprot_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    awprot_i == 3'b000)
  else
  begin
    fail_count++;
    $error("awprot is not zero");
  end

  cmd_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i)
  else
  begin
    fail_count++;
    $error("cmd_v dropped before cmd_ready");
  end

  resp_exclusive_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rvalid_i && bvalid_i))
  else
  begin
    fail_count++;
    $error("rvalid and bvalid high together");
  end

  rvalid_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i)
  else
  begin
    fail_count++;
    $error("rvalid dropped before rready");
  end

  // Memory stays busy while the adaptor owes a response
  resp_busy_a: assert property (@(posedge clk_i) disable iff (reset_i)
    state_i != axil_bridge_pkg::e_wait |-> !cmd_ready_i)
  else
  begin
    fail_count++;
    $error("memory ready while a response is outstanding");
  end

endmodule

bind axil_client_adaptor axil_mem_checker checker_i
(
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .awprot_i    (s_axil_awprot_i),
  .cmd_v_i     (cmd_v_o),
  .cmd_ready_i (cmd_ready_i),
  .rvalid_i    (s_axil_rvalid_o),
  .rready_i    (s_axil_rready_i),
  .bvalid_i    (s_axil_bvalid_o),
  .state_i     (state_r)
);

`default_nettype wire

/* tests/axil_mem_tb.sv */
`default_nettype none

module axil_mem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 32;
  localparam int mem_words_lp  = 64;
  localparam int latency_lp    = 3;
  localparam int num_trans_lp  = 300;
  // Init writes plus random traffic, each with room for stalls
  localparam int timeout_lp    = (mem_words_lp + num_trans_lp) * (latency_lp + 20);

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic [31:0] s_axil_awaddr_i;
  logic [2:0]  s_axil_awprot_i;
  logic        s_axil_awvalid_i;
  logic        s_axil_awready_o;
  logic [31:0] s_axil_wdata_i;
  logic [3:0]  s_axil_wstrb_i;
  logic        s_axil_wvalid_i;
  logic        s_axil_wready_o;
  logic [1:0]  s_axil_bresp_o;
  logic        s_axil_bvalid_o;
  logic        s_axil_bready_i;
  logic [31:0] s_axil_araddr_i;
  logic [2:0]  s_axil_arprot_i;
  logic        s_axil_arvalid_i;
  logic        s_axil_arready_o;
  logic [31:0] s_axil_rdata_o;
  logic [1:0]  s_axil_rresp_o;
  logic        s_axil_rvalid_o;
  logic        s_axil_rready_i;

  // Byte-wide reference memory
  logic [7:0]  model_mem [mem_words_lp*4];
  int unsigned cyc = 0;
  int unsigned acc_edge;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned issued = 0;
  int unsigned responses = 0;

  axil_mem_top
  #(
    .axil_data_width_p(data_width_lp),
    .axil_addr_width_p(addr_width_lp),
    .mem_words_p      (mem_words_lp),
    .resp_latency_p   (latency_lp)
  )
  axil_mem_top_i
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i)
  );

  always #4 clk_i = ~clk_i;

  // Counts rising edges, sampled at the falling edge
  always @(posedge clk_i)
    cyc <= cyc + 1;

  // Response handshakes seen on the bus, one per transaction expected
  always @(negedge clk_i)
  begin
    if (!reset_i && s_axil_rvalid_o && s_axil_rready_i)
      responses++;
    if (!reset_i && s_axil_bvalid_o && s_axil_bready_i)
      responses++;
  end

  function automatic logic [31:0] model_word(int unsigned idx);
    return {model_mem[4*idx+3], model_mem[4*idx+2], model_mem[4*idx+1], model_mem[4*idx]};
  endfunction

  // Strobes 1, 3 and F cover the low byte, low half and full word
  function automatic void model_write(int unsigned idx, logic [31:0] data, logic [3:0] strb);
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        model_mem[4*idx+i] = data[8*i +: 8];
    end
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("mismatch: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Called at a rising edge, returns at the edge after the handshake
  task automatic accept_read(logic [31:0] addr);
    s_axil_araddr_i  <= addr;
    s_axil_arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!s_axil_arready_o)
      @(negedge clk_i);
    acc_edge = cyc + 1;
    issued++;
    @(posedge clk_i);
    s_axil_arvalid_i <= 1'b0;
  endtask

  task automatic finish_read(string name, logic [31:0] expected);
    bit risen;
    risen = 1'b0;
    forever
    begin
      s_axil_rready_i <= 1'($urandom_range(1, 0));
      @(negedge clk_i);
      if (s_axil_rvalid_o && !risen)
      begin
        risen = 1'b1;
        check_value({name, " rvalid latency"}, acc_edge + latency_lp, cyc);
      end
      if (s_axil_rvalid_o && s_axil_rready_i)
        break;
      @(posedge clk_i);
    end
    check_value({name, " rresp"}, axil_bridge_pkg::axi_resp_okay, s_axil_rresp_o);
    check_value(name, expected, s_axil_rdata_o);
    @(posedge clk_i);
    s_axil_rready_i <= 1'b0;
  endtask

  task automatic accept_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
    s_axil_awaddr_i  <= addr;
    s_axil_wdata_i   <= data;
    s_axil_wstrb_i   <= strb;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    @(negedge clk_i);
    while (!(s_axil_awready_o && s_axil_wready_o))
      @(negedge clk_i);
    acc_edge = cyc + 1;
    issued++;
    @(posedge clk_i);
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
  endtask

  task automatic finish_write(string name);
    bit risen;
    risen = 1'b0;
    forever
    begin
      s_axil_bready_i <= 1'($urandom_range(1, 0));
      @(negedge clk_i);
      if (s_axil_bvalid_o && !risen)
      begin
        risen = 1'b1;
        check_value({name, " bvalid latency"}, acc_edge + latency_lp, cyc);
      end
      if (s_axil_bvalid_o && s_axil_bready_i)
        break;
      @(posedge clk_i);
    end
    check_value({name, " bresp"}, axil_bridge_pkg::axi_resp_okay, s_axil_bresp_o);
    @(posedge clk_i);
    s_axil_bready_i <= 1'b0;
  endtask

  // Read and write raised together, the read has to go first
  task automatic race_read_write(int unsigned rd_idx, int unsigned wr_idx, logic [31:0] data);
    logic [31:0] old_word;
    old_word = model_word(rd_idx);
    s_axil_awaddr_i  <= wr_idx * 4;
    s_axil_wdata_i   <= data;
    s_axil_wstrb_i   <= 4'hF;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    s_axil_araddr_i  <= rd_idx * 4;
    s_axil_arvalid_i <= 1'b1;
    @(negedge clk_i);
    check_value("race arready", 1, s_axil_arready_o);
    check_value("race awready", 0, s_axil_awready_o);
    acc_edge = cyc + 1;
    issued++;
    @(posedge clk_i);
    s_axil_arvalid_i <= 1'b0;
    finish_read("race read", old_word);
    model_write(wr_idx, data, 4'hF);
    accept_write(wr_idx * 4, data, 4'hF);
    finish_write("race write");
    accept_read(wr_idx * 4);
    finish_read("race readback", model_word(wr_idx));
  endtask

  initial
  begin
    repeat (timeout_lp) @(posedge clk_i);
    $display("Timeout: the transactions did not finish within %0d cycles", timeout_lp);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int unsigned idx;
    int unsigned kind;
    logic [31:0] data;
    logic [3:0]  strb;
    void'($urandom(32'h8fb0c7ad));
    reset_i          = 1'b1;
    s_axil_awaddr_i  = '0;
    s_axil_awprot_i  = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wstrb_i   = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b0;
    s_axil_araddr_i  = '0;
    s_axil_arprot_i  = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int w = 0; w < mem_words_lp; w++)
    begin
      data = $urandom();
      model_write(w, data, 4'hF);
      accept_write(w * 4, data, 4'hF);
      finish_write("init write");
    end

    for (int t = 0; t < num_trans_lp; t++)
    begin
      idx  = $urandom_range(mem_words_lp - 1, 0);
      kind = $urandom_range(15, 0);
      data = $urandom();
      if (kind == 0)
        race_read_write($urandom_range(mem_words_lp - 1, 0), idx, data);
      else if (kind < 8)
      begin
        // Low address bits must not matter
        accept_read(idx * 4 + $urandom_range(3, 0));
        finish_read("random read", model_word(idx));
      end
      else
      begin
        case ($urandom_range(2, 0))
          0: strb = 4'h1;
          1: strb = 4'h3;
          default: strb = 4'hF;
        endcase
        model_write(idx, data, strb);
        accept_write(idx * 4 + $urandom_range(3, 0), data, strb);
        finish_write("random write");
      end
    end

    check_value("response count", issued, responses);
    errors += axil_mem_top_i.adaptor_i.checker_i.fail_count;
    $display("Checks: %0d, errors: %0d, issued: %0d, responses: %0d",
             checks, errors, issued, responses);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/axil_bridge_pkg.sv */
`default_nettype none

package axil_bridge_pkg;

  // Adaptor FSM states
  typedef enum logic [1:0]
  {
    e_wait       = 2'b00,
    e_read_resp  = 2'b01,
    e_write_resp = 2'b10
  } adaptor_state_e;

  // Host transfer size, encoded as log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_byte   = 2'b00,
    e_size_half   = 2'b01,
    e_size_word   = 2'b10,
    e_size_double = 2'b11
  } cmd_size_e;

  // AXI response codes, only OKAY is ever returned
  localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

`default_nettype wire

/* verilog/axil_client_adaptor.sv */
`default_nettype none

module axil_client_adaptor
#(
  parameter int axil_data_width_p = 32,
  parameter int axil_addr_width_p = 32
)
(
  input  wire logic                               clk_i,
  input  wire logic                               reset_i,

  // Host command and response
  output logic                                    cmd_v_o,
  input  wire logic                               cmd_ready_i,
  output logic [axil_addr_width_p-1:0]            cmd_addr_o,
  output logic                                    cmd_wr_en_o,
  output axil_bridge_pkg::cmd_size_e              cmd_data_size_o,
  output logic [axil_data_width_p-1:0]            cmd_wdata_o,
  input  wire logic                               resp_v_i,
  output logic                                    resp_ready_o,
  input  wire logic [axil_data_width_p-1:0]       resp_rdata_i,

  // AXI4-Lite write address
  input  wire logic [axil_addr_width_p-1:0]       s_axil_awaddr_i,
  input  wire logic [2:0]                         s_axil_awprot_i,
  input  wire logic                               s_axil_awvalid_i,
  output logic                                    s_axil_awready_o,

  // AXI4-Lite write data
  input  wire logic [axil_data_width_p-1:0]       s_axil_wdata_i,
  input  wire logic [(axil_data_width_p>>3)-1:0]  s_axil_wstrb_i,
  input  wire logic                               s_axil_wvalid_i,
  output logic                                    s_axil_wready_o,

  // AXI4-Lite write response
  output logic [1:0]                              s_axil_bresp_o,
  output logic                                    s_axil_bvalid_o,
  input  wire logic                               s_axil_bready_i,

  // AXI4-Lite read address
  input  wire logic [axil_addr_width_p-1:0]       s_axil_araddr_i,
  input  wire logic [2:0]                         s_axil_arprot_i,
  input  wire logic                               s_axil_arvalid_i,
  output logic                                    s_axil_arready_o,

  // AXI4-Lite read data
  output logic [axil_data_width_p-1:0]            s_axil_rdata_o,
  output logic [1:0]                              s_axil_rresp_o,
  output logic                                    s_axil_rvalid_o,
  input  wire logic                               s_axil_rready_i
);

  localparam int strb_width_lp = axil_data_width_p >> 3;
  localparam int lsb_lp = $clog2(strb_width_lp);
  localparam axil_bridge_pkg::cmd_size_e size_full_lp = (axil_data_width_p == 64)
    ? axil_bridge_pkg::e_size_double : axil_bridge_pkg::e_size_word;

  axil_bridge_pkg::adaptor_state_e state_r;
  axil_bridge_pkg::adaptor_state_e state_n;
  axil_bridge_pkg::cmd_size_e      wr_size;

  if (axil_data_width_p != 32 && axil_data_width_p != 64)
  begin : g_width_check
    $fatal(1, "AXI4-Lite data width must be 32 or 64, got %0d", axil_data_width_p);
  end

  // Strobe to size, odd patterns fall back to a full-width write
  always_comb
  begin
    wr_size = size_full_lp;
    if (s_axil_wstrb_i == strb_width_lp'(1))
      wr_size = axil_bridge_pkg::e_size_byte;
    else if (s_axil_wstrb_i == strb_width_lp'(3))
      wr_size = axil_bridge_pkg::e_size_half;
    else if (s_axil_wstrb_i == strb_width_lp'(4'hF))
      wr_size = axil_bridge_pkg::e_size_word;
  end

  always_comb
  begin
    state_n          = state_r;
    cmd_v_o          = 1'b0;
    cmd_addr_o       = '0;
    cmd_wr_en_o      = 1'b0;
    cmd_data_size_o  = size_full_lp;
    cmd_wdata_o      = '0;
    resp_ready_o     = 1'b0;
    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_arready_o = 1'b0;
    s_axil_bresp_o   = axil_bridge_pkg::axi_resp_okay;
    s_axil_bvalid_o  = 1'b0;
    s_axil_rdata_o   = '0;
    s_axil_rresp_o   = axil_bridge_pkg::axi_resp_okay;
    s_axil_rvalid_o  = 1'b0;

    unique case (state_r)
      axil_bridge_pkg::e_wait:
      begin
        // Reads take priority over writes
        if (s_axil_arvalid_i)
        begin
          cmd_v_o          = 1'b1;
          cmd_addr_o       = {s_axil_araddr_i[axil_addr_width_p-1:lsb_lp], lsb_lp'(0)};
          s_axil_arready_o = cmd_ready_i;
          if (cmd_ready_i)
            state_n = axil_bridge_pkg::e_read_resp;
        end
        else if (s_axil_awvalid_i && s_axil_wvalid_i)
        begin
          cmd_v_o          = 1'b1;
          cmd_addr_o       = s_axil_awaddr_i;
          cmd_wr_en_o      = 1'b1;
          cmd_data_size_o  = wr_size;
          cmd_wdata_o      = s_axil_wdata_i;
          s_axil_awready_o = cmd_ready_i;
          s_axil_wready_o  = cmd_ready_i;
          if (cmd_ready_i)
            state_n = axil_bridge_pkg::e_write_resp;
        end
      end

      axil_bridge_pkg::e_read_resp:
      begin
        s_axil_rdata_o  = resp_rdata_i;
        s_axil_rvalid_o = resp_v_i;
        resp_ready_o    = s_axil_rready_i;
        if (resp_v_i && s_axil_rready_i)
          state_n = axil_bridge_pkg::e_wait;
      end

      axil_bridge_pkg::e_write_resp:
      begin
        s_axil_bvalid_o = resp_v_i;
        resp_ready_o    = s_axil_bready_i;
        if (resp_v_i && s_axil_bready_i)
          state_n = axil_bridge_pkg::e_wait;
      end

      default: state_n = axil_bridge_pkg::e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= axil_bridge_pkg::e_wait;
    else
      state_r <= state_n;
  end

endmodule

`default_nettype wire

/* verilog/axil_mem_top.sv */
`default_nettype none

module axil_mem_top
#(
  parameter int axil_data_width_p = 32,
  parameter int axil_addr_width_p = 32,
  parameter int mem_words_p       = 64,
  parameter int resp_latency_p    = 3
)
(
  input  wire logic                               clk_i,
  input  wire logic                               reset_i,

  input  wire logic [axil_addr_width_p-1:0]       s_axil_awaddr_i,
  input  wire logic [2:0]                         s_axil_awprot_i,
  input  wire logic                               s_axil_awvalid_i,
  output logic                                    s_axil_awready_o,

  input  wire logic [axil_data_width_p-1:0]       s_axil_wdata_i,
  input  wire logic [(axil_data_width_p>>3)-1:0]  s_axil_wstrb_i,
  input  wire logic                               s_axil_wvalid_i,
  output logic                                    s_axil_wready_o,

  output logic [1:0]                              s_axil_bresp_o,
  output logic                                    s_axil_bvalid_o,
  input  wire logic                               s_axil_bready_i,

  input  wire logic [axil_addr_width_p-1:0]       s_axil_araddr_i,
  input  wire logic [2:0]                         s_axil_arprot_i,
  input  wire logic                               s_axil_arvalid_i,
  output logic                                    s_axil_arready_o,

  output logic [axil_data_width_p-1:0]            s_axil_rdata_o,
  output logic [1:0]                              s_axil_rresp_o,
  output logic                                    s_axil_rvalid_o,
  input  wire logic                               s_axil_rready_i
);

  logic                          cmd_v;
  logic                          cmd_ready;
  logic [axil_addr_width_p-1:0]  cmd_addr;
  logic                          cmd_wr_en;
  axil_bridge_pkg::cmd_size_e    cmd_data_size;
  logic [axil_data_width_p-1:0]  cmd_wdata;
  logic                          resp_v;
  logic                          resp_ready;
  logic [axil_data_width_p-1:0]  resp_rdata;
  logic                          accept;
  logic                          expired;
  logic                          resp_fire;

  // The response handshake also rearms the timer
  assign resp_fire = resp_v & resp_ready;

  axil_client_adaptor
  #(
    .axil_data_width_p(axil_data_width_p),
    .axil_addr_width_p(axil_addr_width_p)
  )
  adaptor_i
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cmd_v_o          (cmd_v),
    .cmd_ready_i      (cmd_ready),
    .cmd_addr_o       (cmd_addr),
    .cmd_wr_en_o      (cmd_wr_en),
    .cmd_data_size_o  (cmd_data_size),
    .cmd_wdata_o      (cmd_wdata),
    .resp_v_i         (resp_v),
    .resp_ready_o     (resp_ready),
    .resp_rdata_i     (resp_rdata),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i)
  );

  host_mem
  #(
    .axil_data_width_p(axil_data_width_p),
    .axil_addr_width_p(axil_addr_width_p),
    .mem_words_p      (mem_words_p)
  )
  mem_i
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_v_i         (cmd_v),
    .cmd_ready_o     (cmd_ready),
    .cmd_addr_i      (cmd_addr),
    .cmd_wr_en_i     (cmd_wr_en),
    .cmd_data_size_i (cmd_data_size),
    .cmd_wdata_i     (cmd_wdata),
    .accept_o        (accept),
    .expired_i       (expired),
    .resp_v_o        (resp_v),
    .resp_ready_i    (resp_ready),
    .resp_rdata_o    (resp_rdata)
  );

  resp_delay_timer
  #(
    .resp_latency_p(resp_latency_p)
  )
  timer_i
  (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (accept),
    .clear_i   (resp_fire),
    .expired_o (expired)
  );

endmodule

`default_nettype wire

/* verilog/host_mem.sv */
`default_nettype none

module host_mem
#(
  parameter int axil_data_width_p = 32,
  parameter int axil_addr_width_p = 32,
  parameter int mem_words_p       = 64
)
(
  input  wire logic                          clk_i,
  input  wire logic                          reset_i,

  input  wire logic                          cmd_v_i,
  output logic                               cmd_ready_o,
  input  wire logic [axil_addr_width_p-1:0]  cmd_addr_i,
  input  wire logic                          cmd_wr_en_i,
  input  wire axil_bridge_pkg::cmd_size_e    cmd_data_size_i,
  input  wire logic [axil_data_width_p-1:0]  cmd_wdata_i,
  output logic                               accept_o,

  input  wire logic                          expired_i,
  output logic                               resp_v_o,
  input  wire logic                          resp_ready_i,
  output logic [axil_data_width_p-1:0]       resp_rdata_o
);

  localparam int bytes_lp     = axil_data_width_p >> 3;
  localparam int lsb_lp       = $clog2(bytes_lp);
  localparam int idx_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  logic [axil_data_width_p-1:0] mem_r [mem_words_p];
  logic [axil_data_width_p-1:0] rdata_r;
  logic [idx_width_lp-1:0]      word_idx;
  logic [bytes_lp-1:0]          byte_mask;
  logic                         pending_r;
  logic                         accept_r;
  logic                         cmd_fire;
  logic                         resp_fire;

  assign cmd_ready_o  = ~pending_r;
  assign cmd_fire     = cmd_v_i & cmd_ready_o;
  assign resp_v_o     = pending_r & expired_i;
  assign resp_fire    = resp_v_o & resp_ready_i;
  assign resp_rdata_o = rdata_r;
  assign accept_o     = accept_r;

  // Byte offset dropped, index wraps at the memory depth
  assign word_idx = idx_width_lp'((cmd_addr_i >> lsb_lp) % mem_words_p);

  // Low bytes touched by each write size
  always_comb
  begin
    unique case (cmd_data_size_i)
      axil_bridge_pkg::e_size_byte: byte_mask = bytes_lp'(1);
      axil_bridge_pkg::e_size_half: byte_mask = bytes_lp'(3);
      axil_bridge_pkg::e_size_word: byte_mask = bytes_lp'(4'hF);
      default:                      byte_mask = '1;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire && cmd_wr_en_i)
    begin
      for (int i = 0; i < bytes_lp; i++)
      begin
        if (byte_mask[i])
          mem_r[word_idx][8*i +: 8] <= cmd_wdata_i[8*i +: 8];
      end
    end
    if (cmd_fire && !cmd_wr_en_i)
      rdata_r <= mem_r[word_idx];
  end

  // One command in flight until its response is taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pending_r <= 1'b0;
      accept_r  <= 1'b0;
    end
    else
    begin
      accept_r <= cmd_fire;
      if (cmd_fire)
        pending_r <= 1'b1;
      else if (resp_fire)
        pending_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/resp_delay_timer.sv */
`default_nettype none

module resp_delay_timer
#(
  parameter int resp_latency_p = 3
)
(
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic start_i,
  input  wire logic clear_i,
  output logic      expired_o
);

  localparam int cnt_width_lp = $clog2(resp_latency_p) + 1;

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    expired_r;

  assign expired_o = expired_r;

  // Start arrives one cycle after the accepting edge, so load latency-1
  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
    begin
      cnt_r     <= '0;
      expired_r <= 1'b0;
    end
    else if (start_i)
    begin
      cnt_r     <= cnt_width_lp'(resp_latency_p - 1);
      expired_r <= (resp_latency_p == 1);
    end
    else if (cnt_r != '0)
    begin
      cnt_r <= cnt_r - 1'b1;
      if (cnt_r == cnt_width_lp'(1))
        expired_r <= 1'b1;
    end
  end

endmodule

`default_nettype wire
